/* logic/decode_pkg.sv */
package decode_pkg;

    // Core widths
    localparam int INSTR_WIDTH   = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int GPR_NUM       = 32;
    localparam int REG_IDX_WIDTH = $clog2(GPR_NUM);

    typedef logic [INSTR_WIDTH-1:0]   instr_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [DATA_WIDTH-1:0]    data_t;

    // Raw immediate fields as they sit in the instruction word
    typedef logic [19:0] imm20_t;
    typedef logic [11:0] imm12_t;

    // Opcode field widths of the two formats
    typedef logic [6:0] op7_t;
    typedef logic [9:0] op10_t;

    // 1RI20 major opcodes, compared against instr[31:25]
    localparam op7_t OP_LU12I_W   = 7'b0001010;
    localparam op7_t OP_PCADDI    = 7'b0001100;
    localparam op7_t OP_PCADDU12I = 7'b0001110;

    // 2RI12 opcodes, compared against instr[31:22]
    localparam op10_t OP_SLTI   = 10'b0000001000;
    localparam op10_t OP_SLTUI  = 10'b0000001001;
    localparam op10_t OP_ADDI_W = 10'b0000001010;
    localparam op10_t OP_ANDI   = 10'b0000001101;
    localparam op10_t OP_ORI    = 10'b0000001110;
    localparam op10_t OP_XORI   = 10'b0000001111;

    // ALU operation
    typedef enum logic [3:0] {
        ALU_NOP   = 4'd0,
        ALU_ADD   = 4'd1,
        ALU_SLT   = 4'd2,
        ALU_SLTU  = 4'd3,
        ALU_AND   = 4'd4,
        ALU_OR    = 4'd5,
        ALU_XOR   = 4'd6,
        ALU_LUI   = 4'd7,
        ALU_PCADD = 4'd8
    } alu_op_e;

    // Which result group the execute stage writes back
    typedef enum logic [1:0] {
        SEL_NONE  = 2'd0,
        SEL_ARITH = 2'd1,
        SEL_LOGIC = 2'd2,
        SEL_MOVE  = 2'd3
    } alu_sel_e;

endpackage

/* logic/decode_if.sv */
`timescale 1ns/1ps

// One lane's decoded instruction, lane to collector
interface decode_if
    import decode_pkg::*;
();

    logic     instr_valid;
    logic     decode_valid;
    // {rj, rk}
    logic [1:0] reg_read_valid;
    reg_idx_t reg_read_addr_j;
    reg_idx_t reg_read_addr_k;
    logic     use_imm;
    data_t    imm;
    logic     reg_write_valid;
    reg_idx_t reg_write_addr;
    alu_op_e  alu_op;
    alu_sel_e alu_sel;

    modport lane (
        output instr_valid, decode_valid,
        output reg_read_valid, reg_read_addr_j, reg_read_addr_k,
        output use_imm, imm,
        output reg_write_valid, reg_write_addr,
        output alu_op, alu_sel
    );

    modport collector (
        input instr_valid, decode_valid,
        input reg_read_valid, reg_read_addr_j, reg_read_addr_k,
        input use_imm, imm,
        input reg_write_valid, reg_write_addr,
        input alu_op, alu_sel
    );

endinterface

/* logic/instr_splitter.sv */
`timescale 1ns/1ps

// Registers the issue bundle and hands one slot to each lane
module instr_splitter
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                     clk,
    input  logic                     reset_i,

    input  logic [ISSUE_WIDTH-1:0]   instr_valid_i,
    input  instr_t [ISSUE_WIDTH-1:0] instr_i,

    output logic [ISSUE_WIDTH-1:0]   lane_valid_o,
    output instr_t [ISSUE_WIDTH-1:0] lane_instr_o
);

    // Slot strobes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            lane_valid_o <= '0;
        end else begin
            lane_valid_o <= instr_valid_i;
        end
    end

    // Words, zeroed for empty slots so lanes never see stale data
    always_ff @(posedge clk) begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (instr_valid_i[i]) begin
                lane_instr_o[i] <= instr_i[i];
            end else begin
                lane_instr_o[i] <= '0;
            end
        end
    end

endmodule

/* logic/decoder_1ri20.sv */
`timescale 1ns/1ps

// 1RI20 format: {opcode[7], imm20[20], rd[5]}
// LU12I.W, PCADDI, PCADDU12I
// Purely combinational
module decoder_1ri20
    import decode_pkg::*;
(
    input  instr_t   instr_i,

    // High when the opcode belongs to this format
    output logic     decode_valid_o,

    // {rj, rk}, never read here
    output logic [1:0] reg_read_valid_o,

    output logic     use_imm_o,
    output data_t    imm_o,

    output logic     reg_write_valid_o,
    output reg_idx_t reg_write_addr_o,

    output alu_op_e  alu_op_o,
    output alu_sel_e alu_sel_o
);

    reg_idx_t rd;
    imm20_t   imm_20;
    op7_t     opcode;

    assign rd     = instr_i[4:0];
    assign imm_20 = instr_i[24:5];
    assign opcode = instr_i[31:25];

    always_comb begin
        // Defaults for a recognized word
        decode_valid_o    = 1'b1;
        reg_read_valid_o  = 2'b00;
        use_imm_o         = 1'b1;
        imm_o             = {imm_20, 12'b0};
        reg_write_valid_o = 1'b1;
        reg_write_addr_o  = rd;
        alu_op_o          = ALU_NOP;
        alu_sel_o         = SEL_MOVE;
        case (opcode)
            OP_LU12I_W: begin
                alu_op_o = ALU_LUI;
            end
            OP_PCADDI: begin
                alu_op_o = ALU_PCADD;
                // Word offset, sign extended
                imm_o    = {{10{imm_20[19]}}, imm_20, 2'b00};
            end
            OP_PCADDU12I: begin
                alu_op_o = ALU_PCADD;
            end
            default: begin
                // Not ours, everything zero
                decode_valid_o    = 1'b0;
                use_imm_o         = 1'b0;
                imm_o             = '0;
                reg_write_valid_o = 1'b0;
                reg_write_addr_o  = '0;
                alu_sel_o         = SEL_NONE;
            end
        endcase
    end

endmodule

/* logic/decoder_2ri12.sv */
`timescale 1ns/1ps

// 2RI12 format: {opcode[10], imm12[12], rj[5], rd[5]}
// SLTI, SLTUI, ADDI.W, ANDI, ORI, XORI
module decoder_2ri12
    import decode_pkg::*;
(
    input  instr_t   instr_i,

    output logic     decode_valid_o,

    // {rj, rk}
    output logic [1:0] reg_read_valid_o,
    output reg_idx_t reg_read_addr_j_o,

    output logic     use_imm_o,
    output data_t    imm_o,

    output logic     reg_write_valid_o,
    output reg_idx_t reg_write_addr_o,

    output alu_op_e  alu_op_o,
    output alu_sel_e alu_sel_o
);

    reg_idx_t rd;
    reg_idx_t rj;
    imm12_t   imm_12;
    op10_t    opcode;
    data_t    imm_sext;
    data_t    imm_zext;

    assign rd     = instr_i[4:0];
    assign rj     = instr_i[9:5];
    assign imm_12 = instr_i[21:10];
    assign opcode = instr_i[31:22];

    // Both extensions, picked per opcode
    assign imm_sext = {{20{imm_12[11]}}, imm_12};
    assign imm_zext = {20'b0, imm_12};

    always_comb begin
        decode_valid_o    = 1'b1;
        reg_read_valid_o  = 2'b10;
        reg_read_addr_j_o = rj;
        use_imm_o         = 1'b1;
        imm_o             = imm_sext;
        reg_write_valid_o = 1'b1;
        reg_write_addr_o  = rd;
        alu_op_o          = ALU_NOP;
        alu_sel_o         = SEL_ARITH;
        case (opcode)
            OP_SLTI: begin
                alu_op_o = ALU_SLT;
            end
            OP_SLTUI: begin
                // Immediate still sign extended, compare is unsigned
                alu_op_o = ALU_SLTU;
            end
            OP_ADDI_W: begin
                alu_op_o = ALU_ADD;
            end
            OP_ANDI: begin
                alu_op_o  = ALU_AND;
                alu_sel_o = SEL_LOGIC;
                imm_o     = imm_zext;
            end
            OP_ORI: begin
                alu_op_o  = ALU_OR;
                alu_sel_o = SEL_LOGIC;
                imm_o     = imm_zext;
            end
            OP_XORI: begin
                alu_op_o  = ALU_XOR;
                alu_sel_o = SEL_LOGIC;
                imm_o     = imm_zext;
            end
            default: begin
                decode_valid_o    = 1'b0;
                reg_read_valid_o  = 2'b00;
                reg_read_addr_j_o = '0;
                use_imm_o         = 1'b0;
                imm_o             = '0;
                reg_write_valid_o = 1'b0;
                reg_write_addr_o  = '0;
                alu_sel_o         = SEL_NONE;
            end
        endcase
    end

endmodule

/* logic/decode_lane.sv */
`timescale 1ns/1ps

// One decode lane: both format decoders, pick the hit, register it
module decode_lane
    import decode_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,

    input  logic   instr_valid_i,
    input  instr_t instr_i,

    decode_if.lane result
);

    // 1RI20 decoder outputs
    logic       a_valid, a_use_imm, a_wr_valid;
    logic [1:0] a_rd_valid;
    data_t      a_imm;
    reg_idx_t   a_wr_addr;
    alu_op_e    a_op;
    alu_sel_e   a_sel;

    // 2RI12 decoder outputs
    logic       b_valid, b_use_imm, b_wr_valid;
    logic [1:0] b_rd_valid;
    reg_idx_t   b_rj, b_wr_addr;
    data_t      b_imm;
    alu_op_e    b_op;
    alu_sel_e   b_sel;

    // Selected result, before the register
    logic       n_valid, n_use_imm, n_wr_valid;
    logic [1:0] n_rd_valid;
    reg_idx_t   n_rj, n_wr_addr;
    data_t      n_imm;
    alu_op_e    n_op;
    alu_sel_e   n_sel;

    decoder_1ri20 u_dec_1ri20 (
        .instr_i          (instr_i),
        .decode_valid_o   (a_valid),
        .reg_read_valid_o (a_rd_valid),
        .use_imm_o        (a_use_imm),
        .imm_o            (a_imm),
        .reg_write_valid_o(a_wr_valid),
        .reg_write_addr_o (a_wr_addr),
        .alu_op_o         (a_op),
        .alu_sel_o        (a_sel)
    );

    decoder_2ri12 u_dec_2ri12 (
        .instr_i          (instr_i),
        .decode_valid_o   (b_valid),
        .reg_read_valid_o (b_rd_valid),
        .reg_read_addr_j_o(b_rj),
        .use_imm_o        (b_use_imm),
        .imm_o            (b_imm),
        .reg_write_valid_o(b_wr_valid),
        .reg_write_addr_o (b_wr_addr),
        .alu_op_o         (b_op),
        .alu_sel_o        (b_sel)
    );

    // Opcode spaces are disjoint, so at most one decoder hits
    always_comb begin
        n_valid    = 1'b0;
        n_rd_valid = 2'b00;
        n_rj       = '0;
        n_use_imm  = 1'b0;
        n_imm      = '0;
        n_wr_valid = 1'b0;
        n_wr_addr  = '0;
        n_op       = ALU_NOP;
        n_sel      = SEL_NONE;
        if (instr_valid_i && a_valid) begin
            n_valid    = 1'b1;
            n_rd_valid = a_rd_valid;
            n_use_imm  = a_use_imm;
            n_imm      = a_imm;
            n_wr_valid = a_wr_valid;
            n_wr_addr  = a_wr_addr;
            n_op       = a_op;
            n_sel      = a_sel;
        end else if (instr_valid_i && b_valid) begin
            n_valid    = 1'b1;
            n_rd_valid = b_rd_valid;
            n_rj       = b_rj;
            n_use_imm  = b_use_imm;
            n_imm      = b_imm;
            n_wr_valid = b_wr_valid;
            n_wr_addr  = b_wr_addr;
            n_op       = b_op;
            n_sel      = b_sel;
        end
    end

    // Strobes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            result.instr_valid     <= 1'b0;
            result.decode_valid    <= 1'b0;
            result.reg_read_valid  <= 2'b00;
            result.reg_write_valid <= 1'b0;
        end else begin
            result.instr_valid     <= instr_valid_i;
            result.decode_valid    <= n_valid;
            result.reg_read_valid  <= n_rd_valid;
            result.reg_write_valid <= n_wr_valid;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        result.reg_read_addr_j <= n_rj;
        // No format here reads rk
        result.reg_read_addr_k <= '0;
        result.use_imm         <= n_use_imm;
        result.imm             <= n_imm;
        result.reg_write_addr  <= n_wr_addr;
        result.alu_op          <= n_op;
        result.alu_sel         <= n_sel;
    end

endmodule

/* logic/decode_collector.sv */
`timescale 1ns/1ps

// Drains every lane onto flat vectors and reports the first illegal lane
module decode_collector
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2,
    localparam int LANE_IDX_W = (ISSUE_WIDTH > 1) ? $clog2(ISSUE_WIDTH) : 1
) (
    input  logic clk,
    input  logic reset_i,

    decode_if.collector lanes [ISSUE_WIDTH],

    output logic [ISSUE_WIDTH-1:0]       instr_valid_o,
    output logic [ISSUE_WIDTH-1:0]       decode_valid_o,
    output logic [ISSUE_WIDTH-1:0][1:0]  reg_read_valid_o,
    output reg_idx_t [ISSUE_WIDTH-1:0]   reg_read_addr_j_o,
    output reg_idx_t [ISSUE_WIDTH-1:0]   reg_read_addr_k_o,
    output logic [ISSUE_WIDTH-1:0]       use_imm_o,
    output data_t [ISSUE_WIDTH-1:0]      imm_o,
    output logic [ISSUE_WIDTH-1:0]       reg_write_valid_o,
    output reg_idx_t [ISSUE_WIDTH-1:0]   reg_write_addr_o,
    output alu_op_e [ISSUE_WIDTH-1:0]    alu_op_o,
    output alu_sel_e [ISSUE_WIDTH-1:0]   alu_sel_o,
    output logic                         illegal_o,
    output logic [LANE_IDX_W-1:0]        illegal_lane_o
);

    // Valid slot that no decoder recognized
    logic [ISSUE_WIDTH-1:0] lane_bad;
    logic [LANE_IDX_W-1:0]  first_bad;

    for (genvar g = 0; g < ISSUE_WIDTH; g++) begin : g_lane
        assign lane_bad[g] = lanes[g].instr_valid & ~lanes[g].decode_valid;

        always_ff @(posedge clk) begin
            if (reset_i) begin
                instr_valid_o[g]     <= 1'b0;
                decode_valid_o[g]    <= 1'b0;
                reg_read_valid_o[g]  <= 2'b00;
                reg_write_valid_o[g] <= 1'b0;
            end else begin
                instr_valid_o[g]     <= lanes[g].instr_valid;
                decode_valid_o[g]    <= lanes[g].decode_valid;
                reg_read_valid_o[g]  <= lanes[g].reg_read_valid;
                reg_write_valid_o[g] <= lanes[g].reg_write_valid;
            end
        end

        always_ff @(posedge clk) begin
            reg_read_addr_j_o[g] <= lanes[g].reg_read_addr_j;
            reg_read_addr_k_o[g] <= lanes[g].reg_read_addr_k;
            use_imm_o[g]         <= lanes[g].use_imm;
            imm_o[g]             <= lanes[g].imm;
            reg_write_addr_o[g]  <= lanes[g].reg_write_addr;
            alu_op_o[g]          <= lanes[g].alu_op;
            alu_sel_o[g]         <= lanes[g].alu_sel;
        end
    end

    // Lowest index wins, so scan downward
    always_comb begin
        first_bad = '0;
        for (int i = ISSUE_WIDTH - 1; i >= 0; i--) begin
            if (lane_bad[i]) begin
                first_bad = LANE_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            illegal_o      <= 1'b0;
            illegal_lane_o <= '0;
        end else begin
            illegal_o      <= |lane_bad;
            illegal_lane_o <= first_bad;
        end
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

// Multi-issue decode stage, fixed 3 cycle latency
module decode_stage
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2,
    localparam int LANE_IDX_W = (ISSUE_WIDTH > 1) ? $clog2(ISSUE_WIDTH) : 1
) (
    input  logic clk,
    input  logic reset_i,

    input  logic [ISSUE_WIDTH-1:0]       instr_valid_i,
    input  instr_t [ISSUE_WIDTH-1:0]     instr_i,

    output logic [ISSUE_WIDTH-1:0]       instr_valid_o,
    output logic [ISSUE_WIDTH-1:0]       decode_valid_o,
    output logic [ISSUE_WIDTH-1:0][1:0]  reg_read_valid_o,
    output reg_idx_t [ISSUE_WIDTH-1:0]   reg_read_addr_j_o,
    output reg_idx_t [ISSUE_WIDTH-1:0]   reg_read_addr_k_o,
    output logic [ISSUE_WIDTH-1:0]       use_imm_o,
    output data_t [ISSUE_WIDTH-1:0]      imm_o,
    output logic [ISSUE_WIDTH-1:0]       reg_write_valid_o,
    output reg_idx_t [ISSUE_WIDTH-1:0]   reg_write_addr_o,
    output alu_op_e [ISSUE_WIDTH-1:0]    alu_op_o,
    output alu_sel_e [ISSUE_WIDTH-1:0]   alu_sel_o,
    output logic                         illegal_o,
    output logic [LANE_IDX_W-1:0]        illegal_lane_o
);

    logic [ISSUE_WIDTH-1:0]   lane_valid;
    instr_t [ISSUE_WIDTH-1:0] lane_instr;

    decode_if lane_if [ISSUE_WIDTH] ();

    instr_splitter #(
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) u_splitter (
        .clk          (clk),
        .reset_i      (reset_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .lane_valid_o (lane_valid),
        .lane_instr_o (lane_instr)
    );

    for (genvar g = 0; g < ISSUE_WIDTH; g++) begin : g_lane
        decode_lane u_lane (
            .clk          (clk),
            .reset_i      (reset_i),
            .instr_valid_i(lane_valid[g]),
            .instr_i      (lane_instr[g]),
            .result       (lane_if[g])
        );
    end

    decode_collector #(
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) u_collector (
        .clk              (clk),
        .reset_i          (reset_i),
        .lanes            (lane_if),
        .instr_valid_o    (instr_valid_o),
        .decode_valid_o   (decode_valid_o),
        .reg_read_valid_o (reg_read_valid_o),
        .reg_read_addr_j_o(reg_read_addr_j_o),
        .reg_read_addr_k_o(reg_read_addr_k_o),
        .use_imm_o        (use_imm_o),
        .imm_o            (imm_o),
        .reg_write_valid_o(reg_write_valid_o),
        .reg_write_addr_o (reg_write_addr_o),
        .alu_op_o         (alu_op_o),
        .alu_sel_o        (alu_sel_o),
        .illegal_o        (illegal_o),
        .illegal_lane_o   (illegal_lane_o)
    );

endmodule

/* sim/decode_stage_assert.sv */
`timescale 1ns/1ps

// Output checks on the decode stage, bound into the RTL top level
module decode_stage_assert #(
    parameter int ISSUE_WIDTH = 2
) (
    input logic                        clk,
    input logic                        reset_i,
    input logic [ISSUE_WIDTH-1:0]      instr_valid_o,
    input logic [ISSUE_WIDTH-1:0]      decode_valid_o,
    input logic [ISSUE_WIDTH-1:0][1:0] reg_read_valid_o,
    input logic [ISSUE_WIDTH-1:0]      reg_write_valid_o,
    input logic                        illegal_o
);

    // Number of assertion failures so far
    int fail_count = 0;

    // A decoded lane always held a word
    decode_needs_valid: assert property (
        @(posedge clk) disable iff (reset_i)
        (decode_valid_o & ~instr_valid_o) == '0
    ) else begin
        $error("decode_valid_o set on a lane without instr_valid_o");
        fail_count++;
    end

    illegal_matches_lanes: assert property (
        @(posedge clk) disable iff (reset_i)
        illegal_o == |(instr_valid_o & ~decode_valid_o)
    ) else begin
        $error("illegal_o disagrees with the lane valid and decode strobes");
        fail_count++;
    end

    // Collector registers are clear one cycle into reset
    quiet_after_reset: assert property (
        @(posedge clk)
        reset_i |=> (instr_valid_o == '0 && decode_valid_o == '0 &&
                     reg_read_valid_o == '0 && reg_write_valid_o == '0 && !illegal_o)
    ) else begin
        $error("decode stage outputs not quiet after reset");
        fail_count++;
    end

endmodule

bind decode_stage decode_stage_assert #(
    .ISSUE_WIDTH(ISSUE_WIDTH)
) u_assert (
    .clk              (clk),
    .reset_i          (reset_i),
    .instr_valid_o    (instr_valid_o),
    .decode_valid_o   (decode_valid_o),
    .reg_read_valid_o (reg_read_valid_o),
    .reg_write_valid_o(reg_write_valid_o),
    .illegal_o        (illegal_o)
);

/* sim/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb
    import decode_pkg::*;
();

    localparam int ISSUE_WIDTH = 2;
    localparam int LANE_IDX_W  = (ISSUE_WIDTH > 1) ? $clog2(ISSUE_WIDTH) : 1;
    localparam int LATENCY     = 3;
    localparam int DRAIN_LIMIT = 16;

    // Expected outputs of one bundle
    typedef struct packed {
        logic [ISSUE_WIDTH-1:0]      instr_valid;
        logic [ISSUE_WIDTH-1:0]      decode_valid;
        logic [ISSUE_WIDTH-1:0][1:0] rd_valid;
        reg_idx_t [ISSUE_WIDTH-1:0]  rj;
        reg_idx_t [ISSUE_WIDTH-1:0]  rk;
        logic [ISSUE_WIDTH-1:0]      use_imm;
        data_t [ISSUE_WIDTH-1:0]     imm;
        logic [ISSUE_WIDTH-1:0]      wr_valid;
        reg_idx_t [ISSUE_WIDTH-1:0]  wr_addr;
        alu_op_e [ISSUE_WIDTH-1:0]   op;
        alu_sel_e [ISSUE_WIDTH-1:0]  sel;
        logic                        illegal;
        logic [LANE_IDX_W-1:0]       illegal_lane;
    } expect_t;

    logic                        clk;
    logic                        reset_i;
    logic [ISSUE_WIDTH-1:0]      instr_valid_i;
    instr_t [ISSUE_WIDTH-1:0]    instr_i;
    logic [ISSUE_WIDTH-1:0]      instr_valid_o;
    logic [ISSUE_WIDTH-1:0]      decode_valid_o;
    logic [ISSUE_WIDTH-1:0][1:0] reg_read_valid_o;
    reg_idx_t [ISSUE_WIDTH-1:0]  reg_read_addr_j_o;
    reg_idx_t [ISSUE_WIDTH-1:0]  reg_read_addr_k_o;
    logic [ISSUE_WIDTH-1:0]      use_imm_o;
    data_t [ISSUE_WIDTH-1:0]     imm_o;
    logic [ISSUE_WIDTH-1:0]      reg_write_valid_o;
    reg_idx_t [ISSUE_WIDTH-1:0]  reg_write_addr_o;
    alu_op_e [ISSUE_WIDTH-1:0]   alu_op_o;
    alu_sel_e [ISSUE_WIDTH-1:0]  alu_sel_o;
    logic                        illegal_o;
    logic [LANE_IDX_W-1:0]       illegal_lane_o;

    expect_t exp_q[$];
    int      due_q[$];
    int      tick_count  = 0;
    int      check_count = 0;
    int      error_count = 0;
    int      test_count  = 0;

    decode_stage #(
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) dut_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .instr_valid_o    (instr_valid_o),
        .decode_valid_o   (decode_valid_o),
        .reg_read_valid_o (reg_read_valid_o),
        .reg_read_addr_j_o(reg_read_addr_j_o),
        .reg_read_addr_k_o(reg_read_addr_k_o),
        .use_imm_o        (use_imm_o),
        .imm_o            (imm_o),
        .reg_write_valid_o(reg_write_valid_o),
        .reg_write_addr_o (reg_write_addr_o),
        .alu_op_o         (alu_op_o),
        .alu_sel_o        (alu_sel_o),
        .illegal_o        (illegal_o),
        .illegal_lane_o   (illegal_lane_o)
    );

    always #4 clk = ~clk;

    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input alu_op_e got, input alu_op_e exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input alu_sel_e got, input alu_sel_e exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Single strobe bits and small flag fields
    task automatic check_flags(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic logic is_1ri20(input instr_t w);
        return w[31:25] inside {OP_LU12I_W, OP_PCADDI, OP_PCADDU12I};
    endfunction

    function automatic logic is_2ri12(input instr_t w);
        return w[31:22] inside {OP_SLTI, OP_SLTUI, OP_ADDI_W, OP_ANDI, OP_ORI, OP_XORI};
    endfunction

    // Reference decoder for a whole bundle
    function automatic expect_t model_bundle(input logic [ISSUE_WIDTH-1:0] v,
                                             input instr_t [ISSUE_WIDTH-1:0] w);
        expect_t e;
        data_t   ext;
        e = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            e.instr_valid[i] = v[i];
            if (v[i] && is_1ri20(w[i])) begin
                e.decode_valid[i] = 1'b1;
                e.use_imm[i]      = 1'b1;
                e.wr_valid[i]     = 1'b1;
                e.wr_addr[i]      = w[i][4:0];
                e.sel[i]          = SEL_MOVE;
                e.op[i]           = (w[i][31:25] == OP_LU12I_W) ? ALU_LUI : ALU_PCADD;
                ext = data_t'(w[i][24:5]);
                if (w[i][31:25] == OP_PCADDI) begin
                    if (w[i][24]) begin
                        ext = ext | 32'hFFF0_0000;
                    end
                    e.imm[i] = ext << 2;
                end else begin
                    e.imm[i] = ext << 12;
                end
            end else if (v[i] && is_2ri12(w[i])) begin
                e.decode_valid[i] = 1'b1;
                e.rd_valid[i]     = 2'b10;
                e.rj[i]           = w[i][9:5];
                e.use_imm[i]      = 1'b1;
                e.wr_valid[i]     = 1'b1;
                e.wr_addr[i]      = w[i][4:0];
                case (w[i][31:22])
                    OP_SLTI:   e.op[i] = ALU_SLT;
                    OP_SLTUI:  e.op[i] = ALU_SLTU;
                    OP_ADDI_W: e.op[i] = ALU_ADD;
                    OP_ANDI:   e.op[i] = ALU_AND;
                    OP_ORI:    e.op[i] = ALU_OR;
                    default:   e.op[i] = ALU_XOR;
                endcase
                e.imm[i] = data_t'(w[i][21:10]);
                if (e.op[i] inside {ALU_SLT, ALU_SLTU, ALU_ADD}) begin
                    e.sel[i] = SEL_ARITH;
                    if (w[i][21]) begin
                        e.imm[i] = e.imm[i] | 32'hFFFF_F000;
                    end
                end else begin
                    e.sel[i] = SEL_LOGIC;
                end
            end else if (v[i] && !e.illegal) begin
                e.illegal      = 1'b1;
                e.illegal_lane = LANE_IDX_W'(i);
            end
        end
        return e;
    endfunction

    function automatic instr_t gen_1ri20();
        instr_t w;
        w = $urandom();
        case ($urandom_range(2))
            0:       w[31:25] = OP_LU12I_W;
            1:       w[31:25] = OP_PCADDI;
            default: w[31:25] = OP_PCADDU12I;
        endcase
        return w;
    endfunction

    function automatic instr_t gen_2ri12();
        instr_t w;
        w = $urandom();
        case ($urandom_range(5))
            0:       w[31:22] = OP_SLTI;
            1:       w[31:22] = OP_SLTUI;
            2:       w[31:22] = OP_ADDI_W;
            3:       w[31:22] = OP_ANDI;
            4:       w[31:22] = OP_ORI;
            default: w[31:22] = OP_XORI;
        endcase
        return w;
    endfunction

    function automatic instr_t gen_illegal();
        instr_t w;
        w = $urandom();
        // Half the words land next to the opcode tables
        if ($urandom_range(1) == 0) begin
            w[31:26] = 6'b000000;
        end
        if (is_1ri20(w) || is_2ri12(w)) begin
            w[31] = 1'b1;
        end
        return w;
    endfunction

    function automatic instr_t gen_mixed();
        case ($urandom_range(2))
            0:       return gen_1ri20();
            1:       return gen_2ri12();
            default: return gen_illegal();
        endcase
    endfunction

    task automatic compare_bundle(input expect_t e);
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            check_flags($sformatf("instr_valid_o[%0d]", i), instr_valid_o[i], e.instr_valid[i]);
            check_flags($sformatf("decode_valid_o[%0d]", i), decode_valid_o[i],
                        e.decode_valid[i]);
            check_flags($sformatf("reg_read_valid_o[%0d]", i), reg_read_valid_o[i],
                        e.rd_valid[i]);
            check_idx($sformatf("reg_read_addr_j_o[%0d]", i), reg_read_addr_j_o[i], e.rj[i]);
            check_idx($sformatf("reg_read_addr_k_o[%0d]", i), reg_read_addr_k_o[i], e.rk[i]);
            check_flags($sformatf("use_imm_o[%0d]", i), use_imm_o[i], e.use_imm[i]);
            check_data($sformatf("imm_o[%0d]", i), imm_o[i], e.imm[i]);
            check_flags($sformatf("reg_write_valid_o[%0d]", i), reg_write_valid_o[i],
                        e.wr_valid[i]);
            check_idx($sformatf("reg_write_addr_o[%0d]", i), reg_write_addr_o[i], e.wr_addr[i]);
            check_op($sformatf("alu_op_o[%0d]", i), alu_op_o[i], e.op[i]);
            check_sel($sformatf("alu_sel_o[%0d]", i), alu_sel_o[i], e.sel[i]);
        end
        check_flags("illegal_o", illegal_o, e.illegal);
        check_flags("illegal_lane_o", 8'(illegal_lane_o), 8'(e.illegal_lane));
    endtask

    // Advance one cycle, then compare whatever bundle is due now
    task automatic tick();
        expect_t e;
        @(posedge clk);
        #1;
        tick_count++;
        if (due_q.size() != 0 && due_q[0] == tick_count) begin
            e = exp_q.pop_front();
            void'(due_q.pop_front());
            compare_bundle(e);
        end
    endtask

    task automatic send_bundle(input logic [ISSUE_WIDTH-1:0] v,
                               input instr_t [ISSUE_WIDTH-1:0] w);
        instr_valid_i = v;
        instr_i       = w;
        exp_q.push_back(model_bundle(v, w));
        due_q.push_back(tick_count + LATENCY);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        // The last bundle is sampled at the next edge
        tick();
        instr_valid_i = '0;
        instr_i       = '0;
        while (due_q.size() != 0 && waited < DRAIN_LIMIT) begin
            tick();
            waited++;
        end
        if (due_q.size() != 0) begin
            error_count++;
            $display("Timeout: %0d expected bundles never left the pipeline", due_q.size());
        end
    endtask

    task automatic report_test(input string name, input int start);
        test_count++;
        $display("Test %0d %s: %s, %0d errors", test_count, name,
                 (error_count == start) ? "passed" : "failed", error_count - start);
    endtask

    initial begin
        #100000;
        $display("Timeout: simulation did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int                       start;
        logic [ISSUE_WIDTH-1:0]   v;
        instr_t [ISSUE_WIDTH-1:0] w;
        void'($urandom(32'h4f8fb893));
        clk           = 1'b0;
        reset_i       = 1'b1;
        instr_valid_i = '0;
        instr_i       = '0;
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;

        start = error_count;
        for (int n = 0; n < 6; n++) begin
            tick();
            check_flags("instr_valid_o", 8'(instr_valid_o), 8'h00);
            check_flags("decode_valid_o", 8'(decode_valid_o), 8'h00);
            check_flags("reg_write_valid_o", 8'(reg_write_valid_o), 8'h00);
            check_flags("reg_read_valid_o", 8'(reg_read_valid_o), 8'h00);
            check_flags("illegal_o", illegal_o, 1'b0);
        end
        report_test("reset", start);

        start = error_count;
        for (int n = 0; n < 40; n++) begin
            tick();
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                w[i] = gen_1ri20();
                // Negative imm20 on every other bundle
                if (n % 2 == 0) begin
                    w[i][24] = 1'b1;
                end
            end
            send_bundle('1, w);
        end
        drain();
        report_test("1RI20 decode", start);

        start = error_count;
        for (int n = 0; n < 40; n++) begin
            tick();
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                w[i] = gen_2ri12();
            end
            send_bundle('1, w);
        end
        drain();
        report_test("2RI12 decode", start);

        start = error_count;
        for (int n = 0; n < 40; n++) begin
            tick();
            v = $urandom();
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                w[i] = ($urandom_range(1) == 0) ? gen_illegal() : gen_mixed();
            end
            send_bundle(v, w);
        end
        drain();
        report_test("illegal words", start);

        start = error_count;
        for (int n = 0; n < 30; n++) begin
            tick();
            v = $urandom();
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (v[i]) begin
                    w[i] = ($urandom_range(1) == 0) ? gen_1ri20() : gen_2ri12();
                end else begin
                    w[i] = gen_illegal();
                end
            end
            send_bundle(v, w);
        end
        drain();
        report_test("garbage in empty slots", start);

        start = error_count;
        for (int n = 0; n < 200; n++) begin
            tick();
            v = $urandom();
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                w[i] = gen_mixed();
            end
            send_bundle(v, w);
        end
        drain();
        report_test("throughput", start);

        if (dut_i.u_assert.fail_count != 0) begin
            error_count += dut_i.u_assert.fail_count;
            $display("Bound assertions failed %0d times", dut_i.u_assert.fail_count);
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
logic/decode_pkg.sv
logic/decode_if.sv
logic/instr_splitter.sv
logic/decoder_1ri20.sv
logic/decoder_2ri12.sv
logic/decode_lane.sv
logic/decode_collector.sv
logic/decode_stage.sv
sim/decode_stage_assert.sv
sim/decode_stage_tb.sv
